//--- common/axi_stats_pkg.sv
package axi_stats_pkg;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------

  // word index of each readable statistic
  // byte address is index << REG_ADDR_LSB
  typedef enum logic [3:0] {
    STAT_AW_BURST_CNT = 4'd0,
    STAT_AW_BYTES_SUM = 4'd1,
    STAT_W_BURST_CNT  = 4'd2,
    STAT_W_BEAT_CNT   = 4'd3,
    STAT_W_BYTES_SUM  = 4'd4,
    STAT_W_ERR_CNT    = 4'd5,
    STAT_W_STALL_CNT  = 4'd6,
    STAT_B_STALL_CNT  = 4'd7,
    STAT_IDLE_CNT     = 4'd8,
    STAT_AW_DEPTH_MAX = 4'd9
  } stat_id_t;

  // ids 0 to NUM_ACCUM-1 live in the accumulator array
  localparam int NUM_ACCUM = 9;

  // everything software can read, including the depth peak
  localparam int NUM_STATS = 10;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // outstanding AW depth counter and its peak
  localparam int DEPTH_WIDTH = 8;

  // 32-bit registers, so drop two byte-address bits
  localparam int REG_ADDR_LSB = 2;

  // --------------------------------------------------
  // AXI response codes
  // --------------------------------------------------

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

//--- hw/wr_event_decode.sv
`timescale 1ns/1ps

module wr_event_decode
  import axi_stats_pkg::*;
#(
  parameter int STAT_WIDTH     = 32,
  parameter int AXI_STRB_WIDTH = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 stat_clear,

  input  logic                                 awvalid,
  input  logic                                 awready,
  input  logic [7:0]                           awlen,
  input  logic [2:0]                           awsize,

  input  logic                                 wvalid,
  input  logic                                 wready,
  input  logic                                 wlast,
  input  logic [AXI_STRB_WIDTH-1:0]            wstrb,

  input  logic                                 bvalid,
  input  logic                                 bready,
  input  logic [1:0]                           bresp,

  output logic [NUM_ACCUM-1:0]                 stat_en,
  output logic [NUM_ACCUM-1:0][STAT_WIDTH-1:0] stat_amt,
  output logic [DEPTH_WIDTH-1:0]               aw_depth_max
);

  localparam int STRB_CNT_WIDTH = $clog2(AXI_STRB_WIDTH + 1);

  logic                                 aw_xfer;
  logic                                 w_xfer;
  logic                                 b_xfer;
  logic [STRB_CNT_WIDTH-1:0]            w_strb_cnt;
  logic                                 w_in_progress;
  logic [DEPTH_WIDTH-1:0]               aw_depth;
  logic [DEPTH_WIDTH-1:0]               aw_depth_next;
  logic [NUM_ACCUM-1:0]                 en_next;
  logic [NUM_ACCUM-1:0][STAT_WIDTH-1:0] amt_next;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------

  assign aw_xfer = awvalid && awready;
  assign w_xfer  = wvalid && wready;
  assign b_xfer  = bvalid && bready;

  // bytes carried by this beat
  always_comb begin
    w_strb_cnt = '0;
    for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
      w_strb_cnt = w_strb_cnt + STRB_CNT_WIDTH'(wstrb[i]);
    end
  end

  // set after a non-last beat, dropped by the beat with wlast
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_in_progress <= 1'b0;
    end else if (w_xfer) begin
      w_in_progress <= !wlast;
    end
  end

  // --------------------------------------------------
  // outstanding AW depth
  // --------------------------------------------------

  // AW and B in the same cycle cancel out
  // a stray B at depth zero does not wrap the counter
  always_comb begin
    aw_depth_next = aw_depth;
    if (aw_xfer && !b_xfer) begin
      aw_depth_next = aw_depth + 1'b1;
    end else if (b_xfer && !aw_xfer && aw_depth != '0) begin
      aw_depth_next = aw_depth - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      aw_depth     <= '0;
      aw_depth_max <= '0;
    end else begin
      aw_depth <= aw_depth_next;
      if (aw_depth_next > aw_depth_max) begin
        aw_depth_max <= aw_depth_next;
      end
    end
  end

  // --------------------------------------------------
  // per-stat enables and addends
  // --------------------------------------------------

  always_comb begin
    en_next                    = '0;
    en_next[STAT_AW_BURST_CNT] = aw_xfer;
    en_next[STAT_AW_BYTES_SUM] = aw_xfer;
    en_next[STAT_W_BURST_CNT]  = w_xfer && wlast;
    en_next[STAT_W_BEAT_CNT]   = w_xfer;
    en_next[STAT_W_BYTES_SUM]  = w_xfer;
    en_next[STAT_W_ERR_CNT]    = b_xfer && (bresp != RESP_OKAY);
    en_next[STAT_W_STALL_CNT]  = wvalid && !wready;
    en_next[STAT_B_STALL_CNT]  = bvalid && !bready;
    // nothing pending and nothing offered on AW or W
    en_next[STAT_IDLE_CNT]     = (aw_depth == '0) && !w_in_progress && !awvalid && !wvalid;
  end

  // counters and bins step by one, the two byte sums carry a size
  always_comb begin
    for (int i = 0; i < NUM_ACCUM; i++) begin
      amt_next[i] = STAT_WIDTH'(1);
    end
    amt_next[STAT_AW_BYTES_SUM] = (STAT_WIDTH'(awlen) + 1'b1) << awsize;
    amt_next[STAT_W_BYTES_SUM]  = STAT_WIDTH'(w_strb_cnt);
  end

  // a clear drops whatever event lands in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      stat_en <= '0;
    end else begin
      stat_en <= en_next;
    end
  end

  always_ff @(posedge clk) begin
    stat_amt <= amt_next;
  end

endmodule

//--- hw/stat_accum.sv
`timescale 1ns/1ps

// counters use amt of one, sums pass the event size
module stat_accum #(
  parameter int STAT_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clr,
  input  logic                  en,
  input  logic [STAT_WIDTH-1:0] amt,
  output logic [STAT_WIDTH-1:0] value
);

  // wraps silently at full scale
  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      value <= '0;
    end else if (en) begin
      value <= value + amt;
    end
  end

endmodule

//--- hw/stat_readout.sv
`timescale 1ns/1ps

module stat_readout
  import axi_stats_pkg::*;
#(
  parameter int STAT_WIDTH      = 32,
  parameter int AXIL_ADDR_WIDTH = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic [NUM_ACCUM-1:0][STAT_WIDTH-1:0] stat_values,
  input  logic [DEPTH_WIDTH-1:0]               aw_depth_max,

  input  logic                                 arvalid,
  input  logic [AXIL_ADDR_WIDTH-1:0]           araddr,
  output logic                                 arready,

  output logic                                 rvalid,
  output logic [STAT_WIDTH-1:0]                rdata,
  output logic [1:0]                           rresp,
  input  logic                                 rready
);

  localparam int IDX_WIDTH = AXIL_ADDR_WIDTH - REG_ADDR_LSB;

  logic                  ar_accept;
  logic [IDX_WIDTH-1:0]  word_idx;
  stat_id_t              rd_id;
  logic [STAT_WIDTH-1:0] rd_data;
  logic [1:0]            rd_resp;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------

  // one response slot, free when empty or draining this cycle
  assign arready   = !rvalid || rready;
  assign ar_accept = arvalid && arready;

  assign word_idx = araddr[AXIL_ADDR_WIDTH-1:REG_ADDR_LSB];
  assign rd_id    = stat_id_t'(word_idx[3:0]);

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_DECERR;
    if (word_idx < IDX_WIDTH'(NUM_STATS)) begin
      rd_resp = RESP_OKAY;
      case (rd_id)
        STAT_AW_DEPTH_MAX: rd_data = STAT_WIDTH'(aw_depth_max);
        default:           rd_data = stat_values[rd_id];
      endcase
    end
  end

  // --------------------------------------------------
  // response register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // only loaded on acceptance, so data holds under back-pressure
  always_ff @(posedge clk) begin
    if (ar_accept) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

endmodule

//--- hw/axi_wr_stats.sv
`timescale 1ns/1ps

module axi_wr_stats
  import axi_stats_pkg::*;
#(
  parameter int STAT_WIDTH      = 32,
  parameter int AXIL_ADDR_WIDTH = 8,
  parameter int AXI_STRB_WIDTH  = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stat_clear,

  // monitored write port, observed only
  input  logic                       awvalid,
  input  logic                       awready,
  input  logic [7:0]                 awlen,
  input  logic [2:0]                 awsize,
  input  logic                       wvalid,
  input  logic                       wready,
  input  logic                       wlast,
  input  logic [AXI_STRB_WIDTH-1:0]  wstrb,
  input  logic                       bvalid,
  input  logic                       bready,
  input  logic [1:0]                 bresp,

  // AXI-lite register read
  input  logic                       arvalid,
  input  logic [AXIL_ADDR_WIDTH-1:0] araddr,
  output logic                       arready,
  output logic                       rvalid,
  output logic [STAT_WIDTH-1:0]      rdata,
  output logic [1:0]                 rresp,
  input  logic                       rready
);

  logic [NUM_ACCUM-1:0]                 stat_en;
  logic [NUM_ACCUM-1:0][STAT_WIDTH-1:0] stat_amt;
  logic [NUM_ACCUM-1:0][STAT_WIDTH-1:0] stat_values;
  logic [DEPTH_WIDTH-1:0]               aw_depth_max;

  // --------------------------------------------------
  // event decode
  // --------------------------------------------------

  wr_event_decode #(
    .STAT_WIDTH     (STAT_WIDTH),
    .AXI_STRB_WIDTH (AXI_STRB_WIDTH)
  ) u_wr_event_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .stat_clear   (stat_clear),
    .awvalid      (awvalid),
    .awready      (awready),
    .awlen        (awlen),
    .awsize       (awsize),
    .wvalid       (wvalid),
    .wready       (wready),
    .wlast        (wlast),
    .wstrb        (wstrb),
    .bvalid       (bvalid),
    .bready       (bready),
    .bresp        (bresp),
    .stat_en      (stat_en),
    .stat_amt     (stat_amt),
    .aw_depth_max (aw_depth_max)
  );

  // --------------------------------------------------
  // accumulators, one per stat id
  // --------------------------------------------------

  for (genvar i = 0; i < NUM_ACCUM; i++) begin : g_accum
    stat_accum #(
      .STAT_WIDTH (STAT_WIDTH)
    ) u_stat_accum (
      .clk   (clk),
      .rst_n (rst_n),
      .clr   (stat_clear),
      .en    (stat_en[i]),
      .amt   (stat_amt[i]),
      .value (stat_values[i])
    );
  end

  // --------------------------------------------------
  // register readout
  // --------------------------------------------------

  stat_readout #(
    .STAT_WIDTH      (STAT_WIDTH),
    .AXIL_ADDR_WIDTH (AXIL_ADDR_WIDTH)
  ) u_stat_readout (
    .clk          (clk),
    .rst_n        (rst_n),
    .stat_values  (stat_values),
    .aw_depth_max (aw_depth_max),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rresp        (rresp),
    .rready       (rready)
  );

endmodule

//--- verification/axi_wr_stats_tb.sv
`timescale 1ns/1ps

module axi_wr_stats_tb
  import axi_stats_pkg::*;
();

  localparam int STAT_WIDTH      = 32;
  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int AXI_STRB_WIDTH  = 2;
  localparam int NUM_ROWS        = 6;
  // longest row with its register sweep is about 50 cycles
  localparam int ROW_CYCLES      = 100;

  typedef struct packed {
    logic [3:0] bursts;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] strb;
    logic [3:0] w_stall_max;
    logic [3:0] b_delay;
    logic [1:0] bresp;
    logic       aw_first;
  } txn_row_t;

  // bursts, awlen, awsize, wstrb, max W stall, B delay, bresp, AW before W
  txn_row_t rows [NUM_ROWS] = '{
    '{4'd1, 8'd0, 3'd1, 2'b11, 4'd0, 4'd0, 2'b00, 1'b1},
    '{4'd1, 8'd3, 3'd1, 2'b11, 4'd3, 4'd2, 2'b00, 1'b1},
    '{4'd1, 8'd1, 3'd0, 2'b01, 4'd2, 4'd1, 2'b00, 1'b0},
    '{4'd1, 8'd2, 3'd1, 2'b10, 4'd1, 4'd3, 2'b10, 1'b1},
    '{4'd1, 8'd0, 3'd0, 2'b11, 4'd0, 4'd0, 2'b11, 1'b1},
    '{4'd3, 8'd1, 3'd1, 2'b11, 4'd2, 4'd1, 2'b00, 1'b1}
  };
  string row_names [NUM_ROWS] = '{
    "single_okay", "burst4_stall", "w_before_aw", "slverr_resp", "decerr_resp", "outstanding3"
  };

  logic                       clk;
  logic                       rst_n;
  logic                       stat_clear;
  logic                       awvalid;
  logic                       awready;
  logic [7:0]                 awlen;
  logic [2:0]                 awsize;
  logic                       wvalid;
  logic                       wready;
  logic                       wlast;
  logic [AXI_STRB_WIDTH-1:0]  wstrb;
  logic                       bvalid;
  logic                       bready;
  logic [1:0]                 bresp;
  logic                       arvalid;
  logic [AXIL_ADDR_WIDTH-1:0] araddr;
  logic                       arready;
  logic                       rvalid;
  logic [STAT_WIDTH-1:0]      rdata;
  logic [1:0]                 rresp;
  logic                       rready;

  logic [31:0]            model_cnt [NUM_ACCUM];
  logic [31:0]            model_vis [NUM_ACCUM];
  logic [DEPTH_WIDTH-1:0] model_depth;
  logic [DEPTH_WIDTH-1:0] model_peak;
  logic                   model_wip;
  logic [31:0]            rng_state;
  int                     checks = 0;
  int                     value_errors = 0;
  int                     protocol_errors = 0;

  axi_wr_stats #(
    .STAT_WIDTH      (STAT_WIDTH),
    .AXIL_ADDR_WIDTH (AXIL_ADDR_WIDTH),
    .AXI_STRB_WIDTH  (AXI_STRB_WIDTH)
  ) u_axi_wr_stats (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  function automatic logic [31:0] count_ones(input logic [AXI_STRB_WIDTH-1:0] strb);
    logic [31:0] n;
    n = '0;
    for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
      n = n + 32'(strb[i]);
    end
    return n;
  endfunction

  // model_cnt takes an event on its edge, model_vis one edge later,
  // which is the first edge a read can return it
  always @(posedge clk) begin : ref_model
    logic [31:0]            nxt [NUM_ACCUM];
    logic [DEPTH_WIDTH-1:0] depth_nxt;
    logic                   aw_x;
    logic                   w_x;
    logic                   b_x;
    aw_x = awvalid && awready;
    w_x = wvalid && wready;
    b_x = bvalid && bready;
    nxt = model_cnt;
    depth_nxt = model_depth;
    if (aw_x) begin
      nxt[STAT_AW_BURST_CNT] += 1;
      nxt[STAT_AW_BYTES_SUM] += (32'(awlen) + 32'd1) << awsize;
    end
    if (w_x) begin
      nxt[STAT_W_BEAT_CNT] += 1;
      nxt[STAT_W_BYTES_SUM] += count_ones(wstrb);
      if (wlast) nxt[STAT_W_BURST_CNT] += 1;
    end
    if (b_x && bresp != RESP_OKAY) nxt[STAT_W_ERR_CNT] += 1;
    if (wvalid && !wready) nxt[STAT_W_STALL_CNT] += 1;
    if (bvalid && !bready) nxt[STAT_B_STALL_CNT] += 1;
    if (model_depth == '0 && !model_wip && !awvalid && !wvalid) nxt[STAT_IDLE_CNT] += 1;
    if (aw_x && !b_x) begin
      depth_nxt = model_depth + 8'd1;
    end else if (b_x && !aw_x && model_depth != '0) begin
      depth_nxt = model_depth - 8'd1;
    end
    model_vis <= model_cnt;
    if (!rst_n || stat_clear) begin
      model_cnt   <= '{default: '0};
      model_depth <= '0;
      model_peak  <= '0;
    end else begin
      model_cnt   <= nxt;
      model_depth <= depth_nxt;
      if (depth_nxt > model_peak) model_peak <= depth_nxt;
    end
    // the burst-in-progress flag only follows reset and W beats
    if (!rst_n) begin
      model_wip <= 1'b0;
    end else if (w_x) begin
      model_wip <= !wlast;
    end
  end

  // register value a read accepted at this edge returns
  function automatic logic [31:0] expected_reg(input int idx);
    if (idx < NUM_ACCUM) begin
      return model_vis[idx];
    end else if (idx == int'(STAT_AW_DEPTH_MAX)) begin
      return 32'(model_peak);
    end
    return '0;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // --------------------------------------------------
  // monitored port traffic
  // --------------------------------------------------

  task automatic send_aw(input txn_row_t row);
    awvalid <= 1'b1;
    awready <= 1'b1;
    awlen   <= row.awlen;
    awsize  <= row.awsize;
    @(posedge clk);
    awvalid <= 1'b0;
    awready <= 1'b0;
  endtask

  task automatic send_w_burst(input txn_row_t row);
    int stall;
    for (int beat = 0; beat <= row.awlen; beat++) begin
      rng_state = xorshift32(rng_state);
      stall = int'(rng_state % (32'(row.w_stall_max) + 32'd1));
      wvalid <= 1'b1;
      wstrb  <= row.strb;
      wlast  <= (beat == row.awlen);
      wready <= 1'b0;
      repeat (stall) @(posedge clk);
      wready <= 1'b1;
      @(posedge clk);
    end
    wvalid <= 1'b0;
    wready <= 1'b0;
    wlast  <= 1'b0;
  endtask

  task automatic send_b(input txn_row_t row);
    bvalid <= 1'b1;
    bresp  <= row.bresp;
    bready <= 1'b0;
    repeat (row.b_delay) @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bvalid <= 1'b0;
    bready <= 1'b0;
    bresp  <= RESP_OKAY;
  endtask

  task automatic run_row(input txn_row_t row);
    if (row.aw_first) begin
      for (int i = 0; i < row.bursts; i++) send_aw(row);
      for (int i = 0; i < row.bursts; i++) send_w_burst(row);
    end else begin
      for (int i = 0; i < row.bursts; i++) send_w_burst(row);
      for (int i = 0; i < row.bursts; i++) send_aw(row);
    end
    for (int i = 0; i < row.bursts; i++) send_b(row);
    repeat (3) @(posedge clk);
  endtask

  // --------------------------------------------------
  // AXI-lite reads and checks
  // --------------------------------------------------

  task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      value_errors++;
      $display("Error: %s expected 0x%08h actual 0x%08h", test, exp, act);
    end
  endtask

  // hold is the number of cycles rready stays low once rvalid is up
  task automatic read_check(input string test, input int idx, input int hold, input bit want_zero);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    logic [31:0] held_data;
    logic [1:0]  held_resp;
    int          waited;
    arvalid <= 1'b1;
    araddr  <= AXIL_ADDR_WIDTH'(idx << REG_ADDR_LSB);
    rready  <= (hold == 0);
    waited = 0;
    @(posedge clk);
    while (!arready && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    assert (arready) else begin
      protocol_errors++;
      $display("%s: arready stayed low and the read address was never accepted", test);
    end
    exp_data = want_zero ? '0 : expected_reg(idx);
    exp_resp = (idx < NUM_STATS) ? RESP_OKAY : RESP_DECERR;
    // under back-pressure an out-of-range address is offered and has to wait
    arvalid <= (hold > 0);
    araddr  <= '1;
    @(posedge clk);
    assert (rvalid) else begin
      protocol_errors++;
      $display("%s: rvalid did not rise one cycle after the address was accepted", test);
    end
    held_data = rdata;
    held_resp = rresp;
    for (int i = 0; i < hold; i++) begin
      if (i == hold - 1) begin
        rready  <= 1'b1;
        arvalid <= 1'b0;
      end
      @(posedge clk);
      assert (rvalid && rdata === held_data && rresp === held_resp) else begin
        protocol_errors++;
        $display("%s: read response changed while rready was low", test);
      end
    end
    rready <= 1'b1;
    check_value($sformatf("%s reg %0d data", test, idx), exp_data, held_data);
    check_value($sformatf("%s reg %0d resp", test, idx), 32'(exp_resp), 32'(held_resp));
  endtask

  task automatic sweep_regs(input string test, input bit want_zero);
    for (int idx = 0; idx < NUM_STATS; idx++) begin
      read_check(test, idx, 0, want_zero);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin : stimulus
    rst_n      <= 1'b0;
    stat_clear <= 1'b0;
    awvalid    <= 1'b0;
    awready    <= 1'b0;
    awlen      <= '0;
    awsize     <= '0;
    wvalid     <= 1'b0;
    wready     <= 1'b0;
    wlast      <= 1'b0;
    wstrb      <= '0;
    bvalid     <= 1'b0;
    bready     <= 1'b0;
    bresp      <= RESP_OKAY;
    arvalid    <= 1'b0;
    araddr     <= '0;
    rready     <= 1'b1;
    rng_state = 32'h9093_b466;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (arready && !rvalid) else begin
      protocol_errors++;
      $display("read channel not idle after reset");
    end
    sweep_regs("after_reset", 1'b0);
    foreach (rows[r]) begin
      run_row(rows[r]);
      sweep_regs(row_names[r], 1'b0);
    end
    read_check("rready_hold", int'(STAT_W_BEAT_CNT), 4, 1'b0);
    read_check("out_of_range", NUM_STATS, 0, 1'b0);
    read_check("out_of_range_top", 63, 0, 1'b0);
    // awvalid without awready keeps every bin still including idle
    awvalid    <= 1'b1;
    stat_clear <= 1'b1;
    @(posedge clk);
    stat_clear <= 1'b0;
    sweep_regs("after_clear", 1'b1);
    awvalid <= 1'b0;
    @(posedge clk);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    int budget;
    // table rows plus reset, back-pressure, out-of-range and clear phases
    budget = (NUM_ROWS + 4) * ROW_CYCLES;
    repeat (budget) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests finished", budget);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verilog.f
common/axi_stats_pkg.sv
hw/wr_event_decode.sv
hw/stat_accum.sv
hw/stat_readout.sv
hw/axi_wr_stats.sv
verification/axi_wr_stats_tb.sv

//--- Makefile
TOP = axi_wr_stats_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f common/axi_stats_pkg.sv hw/*.sv verification/axi_wr_stats_tb.sv
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP)

# the run fails unless the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module axi_wr_stats

clean:
	rm -rf obj_dir
